//--- source/conv_pkg.sv
package conv_pkg;

  // image geometry
  localparam int img_width  = 128;
  localparam int img_height = 128;
  localparam int pix_count  = img_width * img_height;

  // layer-1 geometry after 2x2 pooling
  localparam int pool_width = img_width / 2;
  localparam int pool_count = pool_width * (img_height / 2);

  typedef logic [7:0]        pixel_t;
  typedef logic [11:0]       feature_t;
  typedef logic signed [2:0] coef_t;

  typedef logic [13:0] img_addr_t;
  typedef logic [13:0] l0_addr_t;
  typedef logic [11:0] l1_addr_t;

  // raster order, top-left tap first
  localparam coef_t kernel [9] = '{
    -3'sd2, 3'sd0, 3'sd1,
    3'sd0,  3'sd1, 3'sd2,
    3'sd1,  3'sd2, -3'sd3
  };

  // flush marks the zero pixels pushed after the frame
  typedef struct packed {
    logic   valid;
    logic   flush;
    pixel_t data;
  } pixel_beat_t;

  typedef struct packed {
    pixel_t [0:8] taps;
    logic         valid;
    logic         top;
    logic         bottom;
    logic         left;
    logic         right;
  } window_t;

  typedef struct packed {
    logic     valid;
    feature_t data;
  } feature_beat_t;

  typedef struct packed {
    logic     wen;
    l0_addr_t addr;
    feature_t data;
  } l0_write_t;

  typedef struct packed {
    logic     wen;
    l1_addr_t addr;
    feature_t data;
  } l1_write_t;

endpackage

//--- source/line_buffer.sv
module line_buffer #(
  parameter type elem_t = conv_pkg::pixel_t,
  parameter int  depth  = conv_pkg::img_width
) (
  input  logic  clk,
  input  logic  en,
  input  elem_t din,
  output elem_t dout
);

  elem_t mem [depth];

  // shift by one element per enable
  always_ff @(posedge clk) begin
    if (en) begin
      mem[0] <= din;
      for (int i = 1; i < depth; i++) begin
        mem[i] <= mem[i-1];
      end
    end
  end

  // element written depth enables ago
  assign dout = mem[depth-1];

endmodule

//--- source/conv_window.sv
module conv_window (
  input  logic                  clk,
  input  logic                  reset,
  input  conv_pkg::pixel_beat_t pix,
  output conv_pkg::window_t     win
);

  conv_pkg::pixel_t       row1_out;
  conv_pkg::pixel_t       row2_out;
  conv_pkg::pixel_t [2:0] top_sr;
  conv_pkg::pixel_t [2:0] mid_sr;
  conv_pkg::pixel_t [2:0] bot_sr;
  logic [7:0] fill_cnt;
  logic [7:0] row;
  logic [7:0] col;
  logic       fire;
  logic       last_center;
  logic       valid_q;
  logic       top_q;
  logic       bottom_q;
  logic       left_q;
  logic       right_q;

  line_buffer #(.elem_t(conv_pkg::pixel_t), .depth(conv_pkg::img_width)) row1_buf (
    .clk  (clk),
    .en   (pix.valid),
    .din  (pix.data),
    .dout (row1_out)
  );

  line_buffer #(.elem_t(conv_pkg::pixel_t), .depth(conv_pkg::img_width)) row2_buf (
    .clk  (clk),
    .en   (pix.valid),
    .din  (row1_out),
    .dout (row2_out)
  );

  // a window is complete once one row plus one pixel has passed the center
  assign fire        = pix.valid && (fill_cnt == 8'(conv_pkg::img_width + 1));
  assign last_center = (row == 8'(conv_pkg::img_height - 1)) &&
                       (col == 8'(conv_pkg::img_width - 1));

  // newest pixel in index 2
  always_ff @(posedge clk) begin
    if (pix.valid) begin
      top_sr <= {row2_out, top_sr[2:1]};
      mid_sr <= {row1_out, mid_sr[2:1]};
      bot_sr <= {pix.data, bot_sr[2:1]};
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fill_cnt <= '0;
      row      <= '0;
      col      <= '0;
      valid_q  <= 1'b0;
      top_q    <= 1'b0;
      bottom_q <= 1'b0;
      left_q   <= 1'b0;
      right_q  <= 1'b0;
    end else begin
      valid_q <= fire;
      if (pix.valid && !fire) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
      if (fire) begin
        top_q    <= (row == '0);
        bottom_q <= (row == 8'(conv_pkg::img_height - 1));
        left_q   <= (col == '0);
        right_q  <= (col == 8'(conv_pkg::img_width - 1));
        if (col == 8'(conv_pkg::img_width - 1)) begin
          col <= '0;
          row <= last_center ? '0 : row + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
        // refill for the next frame once this one completes
        if (last_center) begin
          fill_cnt <= '0;
        end
      end
    end
  end

  always_comb begin
    win.taps   = {top_sr[0], top_sr[1], top_sr[2],
                  mid_sr[0], mid_sr[1], mid_sr[2],
                  bot_sr[0], bot_sr[1], bot_sr[2]};
    win.valid  = valid_q;
    win.top    = top_q;
    win.bottom = bottom_q;
    win.left   = left_q;
    win.right  = right_q;
  end

  col_in_range: assert property (@(posedge clk) disable iff (reset)
    col <= 8'(conv_pkg::img_width - 1));

  // flush beats only arrive once the window is primed
  flush_completes_window: assert property (@(posedge clk) disable iff (reset)
    pix.flush |-> fire);

  // the flush leaves nothing behind the last window
  no_window_after_frame: assert property (@(posedge clk) disable iff (reset)
    win.valid && win.bottom && win.right |=> (!win.valid) [*conv_pkg::img_width]);

endmodule

//--- source/conv_kernel.sv
module conv_kernel (
  input  logic                clk,
  input  logic                reset,
  input  conv_pkg::window_t   win,
  output conv_pkg::l0_write_t l0_write
);

  typedef logic signed [13:0] sum_t;

  sum_t               prod [9];
  sum_t               pair_q [5];
  sum_t               half_q [2];
  sum_t               total;
  sum_t               clipped;
  logic               v1;
  logic               v2;
  logic               wen_q;
  conv_pkg::l0_addr_t addr_q;
  conv_pkg::feature_t data_q;

  // taps outside the image count as zero
  always_comb begin
    for (int i = 0; i < 9; i++) begin
      if ((win.top && i < 3) || (win.bottom && i > 5) ||
          (win.left && i % 3 == 0) || (win.right && i % 3 == 2)) begin
        prod[i] = '0;
      end else begin
        prod[i] = sum_t'($signed({1'b0, win.taps[i]})) * sum_t'(conv_pkg::kernel[i]);
      end
    end
  end

  assign total   = half_q[0] + half_q[1];
  assign clipped = total[13] ? '0 : total;

  always_ff @(posedge clk) begin
    pair_q[0] <= prod[0] + prod[1];
    pair_q[1] <= prod[2] + prod[3];
    pair_q[2] <= prod[4] + prod[5];
    pair_q[3] <= prod[6] + prod[7];
    pair_q[4] <= prod[8];
    half_q[0] <= pair_q[0] + pair_q[1];
    half_q[1] <= pair_q[2] + pair_q[3] + pair_q[4];
    data_q    <= clipped[11:0];
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      v1     <= 1'b0;
      v2     <= 1'b0;
      wen_q  <= 1'b0;
      addr_q <= '0;
    end else begin
      v1    <= win.valid;
      v2    <= v1;
      wen_q <= v2;
      // wraps to zero after the last pixel of the frame
      if (wen_q) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  assign l0_write = '{wen: wen_q, addr: addr_q, data: data_q};

  clip_fits_feature: assert property (@(posedge clk) disable iff (reset)
    v2 |-> clipped[13:12] == 2'b00);

endmodule

//--- source/max_pool.sv
module max_pool (
  input  logic                    clk,
  input  logic                    reset,
  input  conv_pkg::feature_beat_t l0_beat,
  output conv_pkg::l1_write_t     l1_write,
  output logic                    last_write
);

  conv_pkg::feature_t up;
  conv_pkg::feature_t prev;
  conv_pkg::feature_t prev_up;
  conv_pkg::feature_t block_max;
  conv_pkg::feature_t data_q;
  conv_pkg::l1_addr_t addr_q;
  logic [$clog2(conv_pkg::img_width)-1:0]  col;
  logic [$clog2(conv_pkg::img_height)-1:0] row;
  logic pool_beat;
  logic wen_q;

  function automatic conv_pkg::feature_t max2(input conv_pkg::feature_t a,
                                              input conv_pkg::feature_t b);
    return (a > b) ? a : b;
  endfunction

  // same column, one row back
  line_buffer #(.elem_t(conv_pkg::feature_t), .depth(conv_pkg::img_width)) row_buf (
    .clk  (clk),
    .en   (l0_beat.valid),
    .din  (l0_beat.data),
    .dout (up)
  );

  // odd row and odd column closes a 2x2 block
  assign pool_beat = l0_beat.valid && row[0] && col[0];
  assign block_max = max2(max2(l0_beat.data, prev), max2(up, prev_up));

  always_ff @(posedge clk) begin
    if (l0_beat.valid) begin
      prev    <= l0_beat.data;
      prev_up <= up;
    end
    if (pool_beat) begin
      data_q <= block_max;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      row    <= '0;
      col    <= '0;
      wen_q  <= 1'b0;
      addr_q <= '0;
    end else begin
      wen_q <= pool_beat;
      if (wen_q) begin
        addr_q <= addr_q + 1'b1;
      end
      if (l0_beat.valid) begin
        if (col == conv_pkg::img_width - 1) begin
          col <= '0;
          row <= (row == conv_pkg::img_height - 1) ? '0 : row + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

  assign l1_write   = '{wen: wen_q, addr: addr_q, data: data_q};
  assign last_write = wen_q && (addr_q == conv_pkg::l1_addr_t'(conv_pkg::pool_count - 1));

  no_back_to_back_write: assert property (@(posedge clk) disable iff (reset)
    l1_write.wen |=> !l1_write.wen);

endmodule

//--- source/frame_control.sv
module frame_control (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ready,
  input  conv_pkg::pixel_t      idata,
  input  logic                  last_write,
  output conv_pkg::img_addr_t   iaddr,
  output conv_pkg::pixel_beat_t pix,
  output logic                  busy
);

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_flush,
    st_drain
  } state_t;

  state_t     state;
  state_t     state_next;
  logic [7:0] flush_cnt;
  logic       read_q;
  logic       flush_q;
  logic       last_addr;
  logic       last_flush;

  assign last_addr  = (iaddr == conv_pkg::img_addr_t'(conv_pkg::pix_count - 1));
  // one row plus one pixel of zeros
  assign last_flush = (flush_cnt == 8'(conv_pkg::img_width));

  always_comb begin
    state_next = state;
    case (state)
      st_idle:  if (ready) state_next = st_read;
      st_read:  if (last_addr) state_next = st_flush;
      st_flush: if (last_flush) state_next = st_drain;
      st_drain: if (last_write) state_next = st_idle;
      default:  state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= st_idle;
      iaddr     <= '0;
      flush_cnt <= '0;
      read_q    <= 1'b0;
      flush_q   <= 1'b0;
      busy      <= 1'b0;
    end else begin
      state <= state_next;
      // image memory answers one clock later
      read_q  <= (state == st_read);
      flush_q <= (state == st_flush);
      if (state == st_read) begin
        iaddr <= iaddr + 1'b1;
      end
      if (state == st_flush) begin
        flush_cnt <= last_flush ? '0 : flush_cnt + 1'b1;
      end
      if (state == st_idle && ready) begin
        busy <= 1'b1;
      end else if (state == st_drain && last_write) begin
        busy <= 1'b0;
      end
    end
  end

  always_comb begin
    pix.valid = read_q | flush_q;
    pix.flush = flush_q;
    pix.data  = read_q ? idata : '0;
  end

  beat_inside_busy: assert property (@(posedge clk) disable iff (reset)
    pix.valid |-> busy);

endmodule

//--- source/conv_top.sv
module conv_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                ready,
  input  conv_pkg::pixel_t    idata,
  output logic                busy,
  output conv_pkg::img_addr_t iaddr,
  output conv_pkg::l0_write_t l0_write,
  output conv_pkg::l1_write_t l1_write
);

  conv_pkg::pixel_beat_t   pix;
  conv_pkg::window_t       win;
  conv_pkg::feature_beat_t l0_beat;
  logic                    last_write;

  // layer-0 writes feed the pooling stage directly
  assign l0_beat = '{valid: l0_write.wen, data: l0_write.data};

  frame_control frame_control_inst (
    .clk        (clk),
    .reset      (reset),
    .ready      (ready),
    .idata      (idata),
    .last_write (last_write),
    .iaddr      (iaddr),
    .pix        (pix),
    .busy       (busy)
  );

  conv_window conv_window_inst (
    .clk   (clk),
    .reset (reset),
    .pix   (pix),
    .win   (win)
  );

  conv_kernel conv_kernel_inst (
    .clk      (clk),
    .reset    (reset),
    .win      (win),
    .l0_write (l0_write)
  );

  max_pool max_pool_inst (
    .clk        (clk),
    .reset      (reset),
    .l0_beat    (l0_beat),
    .l1_write   (l1_write),
    .last_write (last_write)
  );

endmodule

//--- tb/tb_conv_model.svh
`ifndef TB_CONV_MODEL_SVH
`define TB_CONV_MODEL_SVH

// input image, expected results and captured writes
conv_pkg::pixel_t   image    [conv_pkg::pix_count];
conv_pkg::feature_t model_l0 [conv_pkg::pix_count];
conv_pkg::feature_t model_l1 [conv_pkg::pool_count];
conv_pkg::feature_t l0_mem   [conv_pkg::pix_count];
conv_pkg::feature_t l1_mem   [conv_pkg::pool_count];

// pixels outside the image read as zero
function automatic int pixel_at(input int r, input int c);
  if (r < 0 || r >= conv_pkg::img_height || c < 0 || c >= conv_pkg::img_width) begin
    return 0;
  end
  return int'(image[r * conv_pkg::img_width + c]);
endfunction

function automatic conv_pkg::feature_t conv_value(input int r, input int c);
  int sum;
  sum = 0;
  for (int dr = -1; dr <= 1; dr++) begin
    for (int dc = -1; dc <= 1; dc++) begin
      sum += int'(conv_pkg::kernel[(dr + 1) * 3 + dc + 1]) * pixel_at(r + dr, c + dc);
    end
  end
  // negative sums clip to zero
  if (sum < 0) begin
    sum = 0;
  end
  return conv_pkg::feature_t'(sum);
endfunction

// max over one 2x2 block of layer-0 values
function automatic conv_pkg::feature_t pool_value(input int pr, input int pc);
  conv_pkg::feature_t best;
  conv_pkg::feature_t v;
  best = '0;
  for (int dr = 0; dr < 2; dr++) begin
    for (int dc = 0; dc < 2; dc++) begin
      v = model_l0[(2 * pr + dr) * conv_pkg::img_width + 2 * pc + dc];
      if (v > best) begin
        best = v;
      end
    end
  end
  return best;
endfunction

task automatic build_model;
  for (int r = 0; r < conv_pkg::img_height; r++) begin
    for (int c = 0; c < conv_pkg::img_width; c++) begin
      model_l0[r * conv_pkg::img_width + c] = conv_value(r, c);
    end
  end
  for (int pr = 0; pr < conv_pkg::img_height / 2; pr++) begin
    for (int pc = 0; pc < conv_pkg::pool_width; pc++) begin
      model_l1[pr * conv_pkg::pool_width + pc] = pool_value(pr, pc);
    end
  end
endtask

`endif

//--- tb/tb_conv.sv
module tb_conv;

  logic                clk;
  logic                reset;
  logic                ready;
  conv_pkg::pixel_t    idata;
  logic                busy;
  conv_pkg::img_addr_t iaddr;
  conv_pkg::l0_write_t l0_write;
  conv_pkg::l1_write_t l1_write;

  conv_pkg::img_addr_t mem_addr;
  integer              seed;
  int                  l0_count;
  int                  l1_count;
  int                  error_count;
  int                  tests_run;
  int                  tests_failed;
  int                  test_errors_start;
  string               test_name;

  `include "tb_conv_model.svh"

  conv_top conv_top_inst (
    .clk      (clk),
    .reset    (reset),
    .ready    (ready),
    .idata    (idata),
    .busy     (busy),
    .iaddr    (iaddr),
    .l0_write (l0_write),
    .l1_write (l1_write)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // image memory, one clock of read latency
  always @(posedge clk) begin
    mem_addr = iaddr;
    #2 idata = image[mem_addr];
  end

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    error_count++;
    $display("Error: test %s, %s expected %0d actual %0d", test_name, what, expected, actual);
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("test %s: %s", test_name, what);
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!reset && l0_write.wen) begin
      l0_order: assert (l0_write.addr == conv_pkg::l0_addr_t'(l0_count))
        else report_mismatch("layer-0 write address", l0_count, l0_write.addr);
      l0_mem[l0_write.addr] = l0_write.data;
      l0_count++;
    end
    if (!reset && l1_write.wen) begin
      l1_order: assert (l1_write.addr == conv_pkg::l1_addr_t'(l1_count))
        else report_mismatch("layer-1 write address", l1_count, l1_write.addr);
      l1_mem[l1_write.addr] = l1_write.data;
      l1_count++;
    end
  end

  write_only_while_busy: assert property (@(negedge clk) disable iff (reset)
    !busy |-> !l0_write.wen && !l1_write.wen)
    else report_failure("a layer write happened while busy was low");

  busy_follows_ready: assert property (@(negedge clk) disable iff (reset)
    ready && !busy |=> busy)
    else report_failure("busy did not rise after a ready strobe in idle");

  task automatic start_test(input string name);
    test_name = name;
    test_errors_start = error_count;
    tests_run++;
  endtask

  task automatic close_test;
    if (error_count == test_errors_start) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, error_count - test_errors_start);
    end
  endtask

  task automatic abort_run(input string reason);
    error_count++;
    $display("test %s: %s", test_name, reason);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic fill_random_image;
    for (int i = 0; i < conv_pkg::pix_count; i++) begin
      image[i] = conv_pkg::pixel_t'($random(seed));
    end
  endtask

  task automatic fill_constant_image(input conv_pkg::pixel_t value);
    for (int i = 0; i < conv_pkg::pix_count; i++) begin
      image[i] = value;
    end
  endtask

  task automatic pulse_ready;
    @(posedge clk);
    #2 ready = 1'b1;
    @(posedge clk);
    #2 ready = 1'b0;
  endtask

  task automatic wait_busy_rise;
    int cycles;
    cycles = 0;
    while (!busy) begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > 4) begin
        abort_run("busy did not rise after the ready strobe");
      end
    end
  endtask

  task automatic wait_busy_fall(input bit strobe_ready);
    int cycles;
    cycles = 0;
    while (busy) begin
      @(posedge clk);
      #2;
      // stray strobes early in the read and during the flush
      ready = strobe_ready && (cycles == 40 || cycles == 16450);
      cycles++;
      if (cycles > 20000) begin
        abort_run("busy did not fall within 20000 cycles of the frame start");
      end
    end
    ready = 1'b0;
  endtask

  task automatic hold_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      idle_busy_low: assert (!busy)
        else report_failure("busy was high while the engine should be idle");
    end
  endtask

  task automatic compare_frame;
    l0_total: assert (l0_count == conv_pkg::pix_count)
      else report_mismatch("layer-0 write count", conv_pkg::pix_count, l0_count);
    l1_total: assert (l1_count == conv_pkg::pool_count)
      else report_mismatch("layer-1 write count", conv_pkg::pool_count, l1_count);
    for (int i = 0; i < conv_pkg::pix_count; i++) begin
      l0_value: assert (l0_mem[i] === model_l0[i])
        else report_mismatch($sformatf("layer-0 value at %0d", i), model_l0[i], l0_mem[i]);
    end
    for (int i = 0; i < conv_pkg::pool_count; i++) begin
      l1_value: assert (l1_mem[i] === model_l1[i])
        else report_mismatch($sformatf("layer-1 value at %0d", i), model_l1[i], l1_mem[i]);
    end
  endtask

  task automatic run_frame(input string name, input bit strobe_ready);
    start_test(name);
    build_model;
    for (int i = 0; i < conv_pkg::pix_count; i++) begin
      l0_mem[i] = 'x;
    end
    for (int i = 0; i < conv_pkg::pool_count; i++) begin
      l1_mem[i] = 'x;
    end
    l0_count = 0;
    l1_count = 0;
    pulse_ready;
    wait_busy_rise;
    wait_busy_fall(strobe_ready);
    // late writes or a restart would show up here
    hold_idle(200);
    compare_frame;
    close_test;
  endtask

  initial begin
    seed = 32'h02fa_10e3;
    error_count = 0;
    tests_run = 0;
    tests_failed = 0;
    l0_count = 0;
    l1_count = 0;
    test_name = "reset";
    reset = 1'b1;
    ready = 1'b0;
    idata = '0;
    repeat (2) @(posedge clk);
    #2 reset = 1'b0;

    start_test("idle_after_reset");
    hold_idle(20);
    idle_no_writes: assert (l0_count == 0 && l1_count == 0)
      else report_failure("a layer write happened before the first ready strobe");
    close_test;

    fill_random_image;
    run_frame("random_frame", 1'b0);

    // corners and edges with a flat image
    fill_constant_image(8'd255);
    run_frame("constant_frame", 1'b0);

    fill_random_image;
    run_frame("ready_while_busy", 1'b1);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+tb
source/conv_pkg.sv
source/line_buffer.sv
source/conv_window.sv
source/conv_kernel.sv
source/max_pool.sv
source/frame_control.sv
source/conv_top.sv
tb/tb_conv.sv
